// File: tcdm_pkg.sv
`default_nettype none

package tcdm_pkg;

    // Requester ports and memory banks.
    localparam int unsigned NumIn     = 4;
    localparam int unsigned NumOut    = 4;

    // Data path widths.
    localparam int unsigned DataWidth = 32;
    localparam int unsigned BeWidth   = 4;
    localparam int unsigned ByteWidth = DataWidth / BeWidth;
    localparam int unsigned AddrWidth = 32;

    // Bank geometry.
    localparam int unsigned BankDepth    = 256;
    localparam int unsigned AddrMemWidth = $clog2(BankDepth);

    // Fixed latency from acceptance to response.
    localparam int unsigned RespLat = 1;

    // Byte address layout.
    // Bits 1..0 select the byte and are dropped.
    localparam int unsigned ByteOffWidth = $clog2(BeWidth);
    // Bits 3..2 pick the bank, so consecutive words interleave.
    localparam int unsigned BankSelWidth = $clog2(NumOut);
    localparam int unsigned BankSelLsb   = ByteOffWidth;
    // Bits 11..4 give the word inside the bank.
    localparam int unsigned MemAddrLsb   = BankSelLsb + BankSelWidth;

    // Enough bits to name one requester.
    localparam int unsigned PortIdxWidth = $clog2(NumIn);

    typedef logic [AddrWidth-1:0]    addr_t;
    typedef logic [DataWidth-1:0]    data_t;
    typedef logic [BeWidth-1:0]      be_t;
    typedef logic [AddrMemWidth-1:0] mem_addr_t;
    typedef logic [BankSelWidth-1:0] bank_sel_t;
    typedef logic [PortIdxWidth-1:0] port_idx_t;

endpackage

`default_nettype wire

// File: tcdm_mem_if.sv
`default_nettype none

// One bank port between the crossbar and a single SRAM bank.
// The bank accepts every request, so there is no grant here.
interface tcdm_mem_if;

    // Request strobe for this bank.
    logic                  req;
    // Word address inside the bank.
    tcdm_pkg::mem_addr_t   add;
    // High for a write.
    logic                  wen;
    tcdm_pkg::data_t       wdata;
    // One enable per byte lane.
    tcdm_pkg::be_t         be;
    // Read word, valid one cycle after a read request.
    tcdm_pkg::data_t       rdata;

    // Crossbar side drives the request.
    modport xbar (
        output req,
        output add,
        output wen,
        output wdata,
        output be,
        input  rdata
    );

    // Bank side answers with read data.
    modport bank (
        input  req,
        input  add,
        input  wen,
        input  wdata,
        input  be,
        output rdata
    );

endinterface

`default_nettype wire

// File: tcdm_rr_arbiter.sv
`default_nettype none

// Round-robin arbiter for one bank.
// The grant is combinational from the requests of the same cycle.
module tcdm_rr_arbiter (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic [tcdm_pkg::NumIn-1:0] req_i,
    output logic [tcdm_pkg::NumIn-1:0] gnt_o,
    output tcdm_pkg::port_idx_t        idx_o
);

    // Port with the highest priority in the current cycle.
    tcdm_pkg::port_idx_t ptr_q;
    tcdm_pkg::port_idx_t ptr_d;
    logic                any_req;

    assign any_req = |req_i;

    // Scan from the farthest offset down to the pointer.
    // The last hit is the first requester at or after the pointer.
    always_comb begin
        tcdm_pkg::port_idx_t cand;
        idx_o = ptr_q;
        for (int k = tcdm_pkg::NumIn - 1; k >= 0; k--) begin
            cand = tcdm_pkg::port_idx_t'((ptr_q + k) % tcdm_pkg::NumIn);
            if (req_i[cand]) begin
                idx_o = cand;
            end
        end
    end

    // One-hot grant, empty when nobody asks.
    always_comb begin
        gnt_o        = '0;
        gnt_o[idx_o] = any_req;
    end

    // Next priority goes to the port just past the winner.
    assign ptr_d = (idx_o == tcdm_pkg::port_idx_t'(tcdm_pkg::NumIn - 1)) ? '0 : idx_o + 1'b1;

    // Pointer only moves when a grant was given.
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ptr_q <= '0;
        end else if (any_req) begin
            ptr_q <= ptr_d;
        end
    end

endmodule

`default_nettype wire

// File: tcdm_bank.sv
`default_nettype none

// Single-port SRAM bank with byte enables.
// Writes land at the next edge, reads show up one cycle later.
module tcdm_bank (
    input  logic     clk_i,
    tcdm_mem_if.bank mem_i
);

    // Storage array.
    tcdm_pkg::data_t mem_q [tcdm_pkg::BankDepth];

    // Byte-masked write path.
    always_ff @(posedge clk_i) begin
        if (mem_i.req && mem_i.wen) begin
            for (int i = 0; i < tcdm_pkg::BeWidth; i++) begin
                // Untouched lanes keep the old content.
                if (mem_i.be[i]) begin
                    mem_q[mem_i.add][i*tcdm_pkg::ByteWidth +: tcdm_pkg::ByteWidth] <=
                        mem_i.wdata[i*tcdm_pkg::ByteWidth +: tcdm_pkg::ByteWidth];
                end
            end
        end
    end

    // Registered read port.
    // The output holds its value when no read is issued.
    always_ff @(posedge clk_i) begin
        if (mem_i.req && !mem_i.wen) begin
            mem_i.rdata <= mem_q[mem_i.add];
        end
    end

endmodule

`default_nettype wire

// File: tcdm_xbar.sv
`default_nettype none

// Crossbar from the requester ports to the word-interleaved banks.
// Request steering is combinational, the response comes back RespLat cycles later.
module tcdm_xbar (
    input  logic                                        clk_i,
    input  logic                                        arst_n_i,
    input  logic                [tcdm_pkg::NumIn-1:0]   req_i,
    input  tcdm_pkg::addr_t     [tcdm_pkg::NumIn-1:0]   add_i,
    input  logic                [tcdm_pkg::NumIn-1:0]   wen_i,
    input  tcdm_pkg::data_t     [tcdm_pkg::NumIn-1:0]   wdata_i,
    input  tcdm_pkg::be_t       [tcdm_pkg::NumIn-1:0]   be_i,
    output logic                [tcdm_pkg::NumIn-1:0]   gnt_o,
    output logic                [tcdm_pkg::NumIn-1:0]   vld_o,
    output tcdm_pkg::data_t     [tcdm_pkg::NumIn-1:0]   rdata_o,
    tcdm_mem_if.xbar                                    bank_o [tcdm_pkg::NumOut]
);

    // Address fields per requester.
    tcdm_pkg::bank_sel_t [tcdm_pkg::NumIn-1:0]  port_sel;
    tcdm_pkg::mem_addr_t [tcdm_pkg::NumIn-1:0]  port_add;

    // Per-bank request and grant vectors, indexed by requester.
    logic [tcdm_pkg::NumOut-1:0][tcdm_pkg::NumIn-1:0] bank_req;
    logic [tcdm_pkg::NumOut-1:0][tcdm_pkg::NumIn-1:0] bank_gnt;
    tcdm_pkg::port_idx_t [tcdm_pkg::NumOut-1:0]       bank_idx;
    tcdm_pkg::data_t     [tcdm_pkg::NumOut-1:0]       bank_rdata;

    // Response pipeline, one stage per cycle of latency.
    logic                [tcdm_pkg::NumOut-1:0] vld_q [tcdm_pkg::RespLat];
    tcdm_pkg::port_idx_t [tcdm_pkg::NumOut-1:0] idx_q [tcdm_pkg::RespLat];

    // Split each byte address into bank select and word address.
    always_comb begin
        for (int p = 0; p < tcdm_pkg::NumIn; p++) begin
            port_sel[p] = add_i[p][tcdm_pkg::BankSelLsb +: tcdm_pkg::BankSelWidth];
            port_add[p] = add_i[p][tcdm_pkg::MemAddrLsb +: tcdm_pkg::AddrMemWidth];
        end
    end

    // Each bank sees only the requesters that address it.
    always_comb begin
        for (int b = 0; b < tcdm_pkg::NumOut; b++) begin
            for (int p = 0; p < tcdm_pkg::NumIn; p++) begin
                bank_req[b][p] = req_i[p] && (port_sel[p] == tcdm_pkg::bank_sel_t'(b));
            end
        end
    end

    for (genvar b = 0; b < tcdm_pkg::NumOut; b++) begin : gen_bank
        // Independent arbitration per bank.
        tcdm_rr_arbiter i_arb (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .req_i    (bank_req[b]),
            .gnt_o    (bank_gnt[b]),
            .idx_o    (bank_idx[b])
        );

        // Winner's payload goes to the bank.
        assign bank_o[b].req   = |bank_req[b];
        assign bank_o[b].add   = port_add[bank_idx[b]];
        assign bank_o[b].wen   = wen_i[bank_idx[b]];
        assign bank_o[b].wdata = wdata_i[bank_idx[b]];
        assign bank_o[b].be    = be_i[bank_idx[b]];

        assign bank_rdata[b] = bank_o[b].rdata;
    end

    // A requester targets one bank only, so the grants never overlap.
    always_comb begin
        gnt_o = '0;
        for (int b = 0; b < tcdm_pkg::NumOut; b++) begin
            gnt_o |= bank_gnt[b];
        end
    end

    // Remember which port owns each bank's answer.
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < tcdm_pkg::RespLat; i++) begin
                vld_q[i] <= '0;
                idx_q[i] <= '0;
            end
        end else begin
            for (int b = 0; b < tcdm_pkg::NumOut; b++) begin
                vld_q[0][b] <= |bank_req[b];
                idx_q[0][b] <= bank_idx[b];
            end
            // Deeper stages only exist for a longer latency.
            for (int i = 1; i < tcdm_pkg::RespLat; i++) begin
                vld_q[i] <= vld_q[i-1];
                idx_q[i] <= idx_q[i-1];
            end
        end
    end

    // Route each bank's answer back to its owner.
    // Up to NumOut ports complete in the same cycle.
    always_comb begin
        vld_o   = '0;
        rdata_o = '0;
        for (int b = 0; b < tcdm_pkg::NumOut; b++) begin
            if (vld_q[tcdm_pkg::RespLat-1][b]) begin
                vld_o[idx_q[tcdm_pkg::RespLat-1][b]]   = 1'b1;
                rdata_o[idx_q[tcdm_pkg::RespLat-1][b]] = bank_rdata[b];
            end
        end
    end

endmodule

`default_nettype wire

// File: tcdm_interconnect_wrap.sv
`default_nettype none

// Top of the memory subsystem.
// Plain requester ports outside, crossbar and banks inside.
module tcdm_interconnect_wrap (
    input  logic                                    clk_i,
    input  logic                                    arst_n_i,

    // Request side, one element per requester.
    input  logic            [tcdm_pkg::NumIn-1:0]   req_i,
    input  tcdm_pkg::addr_t [tcdm_pkg::NumIn-1:0]   add_i,
    input  logic            [tcdm_pkg::NumIn-1:0]   wen_i,
    input  tcdm_pkg::data_t [tcdm_pkg::NumIn-1:0]   wdata_i,
    input  tcdm_pkg::be_t   [tcdm_pkg::NumIn-1:0]   be_i,

    // Grant in the same cycle.
    output logic            [tcdm_pkg::NumIn-1:0]   gnt_o,
    // Response one cycle after acceptance.
    output logic            [tcdm_pkg::NumIn-1:0]   vld_o,
    output tcdm_pkg::data_t [tcdm_pkg::NumIn-1:0]   rdata_o
);

    // One link per bank.
    tcdm_mem_if bank_if [tcdm_pkg::NumOut] ();

    // Address decode, arbitration and response routing.
    tcdm_xbar i_xbar (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (req_i),
        .add_i    (add_i),
        .wen_i    (wen_i),
        .wdata_i  (wdata_i),
        .be_i     (be_i),
        .gnt_o    (gnt_o),
        .vld_o    (vld_o),
        .rdata_o  (rdata_o),
        .bank_o   (bank_if)
    );

    // Word-interleaved banks.
    // Bank b holds every word whose address bits 3..2 equal b.
    for (genvar b = 0; b < tcdm_pkg::NumOut; b++) begin : gen_bank
        tcdm_bank i_bank (
            .clk_i (clk_i),
            .mem_i (bank_if[b])
        );
    end

endmodule

`default_nettype wire

// File: tb_tcdm.sv
`default_nettype none

module tb_tcdm;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ResetCycles   = 4;
    localparam int CyclesPerCase = 20;
    localparam int MaxCases      = 64;
    localparam int NumFields     = 4 * tcdm_pkg::NumIn + 1;

    logic                                       clk;
    logic                                       arst_n;
    logic            [tcdm_pkg::NumIn-1:0]      req;
    tcdm_pkg::addr_t [tcdm_pkg::NumIn-1:0]      add;
    logic            [tcdm_pkg::NumIn-1:0]      wen;
    tcdm_pkg::data_t [tcdm_pkg::NumIn-1:0]      wdata;
    tcdm_pkg::be_t   [tcdm_pkg::NumIn-1:0]      be;
    logic            [tcdm_pkg::NumIn-1:0]      gnt;
    logic            [tcdm_pkg::NumIn-1:0]      vld;
    tcdm_pkg::data_t [tcdm_pkg::NumIn-1:0]      rdata;

    // Transaction groups loaded from the cases file.
    string                                      case_name  [MaxCases];
    logic            [tcdm_pkg::NumIn-1:0]      case_mask  [MaxCases];
    logic            [tcdm_pkg::NumIn-1:0]      case_wen   [MaxCases];
    tcdm_pkg::addr_t [tcdm_pkg::NumIn-1:0]      case_add   [MaxCases];
    tcdm_pkg::data_t [tcdm_pkg::NumIn-1:0]      case_wdata [MaxCases];
    tcdm_pkg::be_t   [tcdm_pkg::NumIn-1:0]      case_be    [MaxCases];
    int                                         num_cases = 0;

    // Reference memory, indexed by byte address bits 11..2.
    tcdm_pkg::data_t                            ref_mem [1024];
    // Round-robin priority per bank that starts at port 0 after reset.
    tcdm_pkg::port_idx_t                        rr_ptr  [tcdm_pkg::NumOut];

    int err_cnt     = 0;
    int pass_cnt    = 0;
    int fail_cnt    = 0;
    int cycle_cnt   = 0;
    int cycle_limit = 0;

    tcdm_interconnect_wrap i_dut (
        .clk_i    (clk),
        .arst_n_i (arst_n),
        .req_i    (req),
        .add_i    (add),
        .wen_i    (wen),
        .wdata_i  (wdata),
        .be_i     (be),
        .gnt_o    (gnt),
        .vld_o    (vld),
        .rdata_o  (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Run guard sized from the number of case lines.
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: the run went past %0d cycles without finishing", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // Byte-lane merge of a write into an old word.
    function automatic tcdm_pkg::data_t merge_bytes(tcdm_pkg::data_t old_word,
                                                   tcdm_pkg::data_t new_word,
                                                   tcdm_pkg::be_t strb);
        tcdm_pkg::data_t res;
        res = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return res;
    endfunction

    // Per bank, the first pending port at or after the pointer wins.
    function automatic logic [tcdm_pkg::NumIn-1:0] predict_grants(
            logic [tcdm_pkg::NumIn-1:0] pend, tcdm_pkg::addr_t [tcdm_pkg::NumIn-1:0] a);
        logic [tcdm_pkg::NumIn-1:0] g;
        logic                       found;
        int                         p;
        g = '0;
        for (int b = 0; b < tcdm_pkg::NumOut; b++) begin
            found = 1'b0;
            for (int k = 0; k < tcdm_pkg::NumIn; k++) begin
                p = (int'(rr_ptr[b]) + k) % tcdm_pkg::NumIn;
                if (!found && pend[p] && a[p][3:2] == 2'(b)) begin
                    g[p]  = 1'b1;
                    found = 1'b1;
                end
            end
        end
        return g;
    endfunction

    // Lines starting with # are column notes.
    task automatic read_cases();
        int          fd;
        int          n;
        int          ch;
        string       tok;
        logic [31:0] val [NumFields];
        fd = $fopen("tcdm_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open tcdm_cases.txt");
            err_cnt++;
            return;
        end
        while (num_cases < MaxCases && $fscanf(fd, "%s", tok) == 1) begin
            if (tok.getc(0) == "#") begin
                // Drop the rest of the note.
                do ch = $fgetc(fd); while (ch != 10 && ch != -1);
                continue;
            end
            n = 0;
            for (int k = 0; k < NumFields; k++) begin
                n += $fscanf(fd, "%h", val[k]);
            end
            if (n != NumFields) begin
                $display("case line %s is incomplete in tcdm_cases.txt", tok);
                err_cnt++;
                break;
            end
            case_name[num_cases] = tok;
            case_mask[num_cases] = val[0][3:0];
            for (int p = 0; p < tcdm_pkg::NumIn; p++) begin
                case_wen[num_cases][p]   = val[1 + 4*p][0];
                case_add[num_cases][p]   = val[2 + 4*p];
                case_wdata[num_cases][p] = val[3 + 4*p];
                case_be[num_cases][p]    = val[4 + 4*p][3:0];
            end
            num_cases++;
        end
        $fclose(fd);
    endtask

    task automatic report_test(string name, int errs_before);
        if (err_cnt == errs_before) begin
            $display("test %s passed", name);
            pass_cnt++;
        end else begin
            $display("test %s failed with %0d errors", name, err_cnt - errs_before);
            fail_cnt++;
        end
    endtask

    // Outputs stay quiet through reset and one idle cycle after it.
    task automatic check_reset_state();
        int errs_before;
        errs_before = err_cnt;
        for (int i = 0; i <= ResetCycles; i++) begin
            @(negedge clk);
            assert (gnt === '0 && vld === '0) else begin
                $display("error reset_state gnt/vld expected %b/%b actual %b/%b",
                         4'b0, 4'b0, gnt, vld);
                err_cnt++;
            end
            if (i == ResetCycles - 1) begin
                @(posedge clk);
                arst_n <= 1'b1;
            end
        end
        report_test("reset_state", errs_before);
    endtask

    // Requests are held until granted and each answer is checked one cycle later.
    task automatic run_case(int c);
        logic [tcdm_pkg::NumIn-1:0] pending;
        logic [tcdm_pkg::NumIn-1:0] outstanding;
        logic [tcdm_pkg::NumIn-1:0] exp_gnt;
        logic [tcdm_pkg::NumIn-1:0] accepted;
        tcdm_pkg::data_t            exp_rdata [tcdm_pkg::NumIn];
        logic [9:0]                 widx;
        int                         errs_before;
        errs_before = err_cnt;
        pending     = case_mask[c];
        outstanding = '0;
        while (pending != '0 || outstanding != '0) begin
            @(posedge clk);
            req   <= pending;
            add   <= case_add[c];
            wen   <= case_wen[c];
            wdata <= case_wdata[c];
            be    <= case_be[c];
            @(negedge clk);
            exp_gnt = predict_grants(pending, case_add[c]);
            assert (gnt === exp_gnt) else begin
                $display("error %s gnt expected %b actual %b", case_name[c], exp_gnt, gnt);
                err_cnt++;
            end
            assert (vld === outstanding) else begin
                $display("error %s vld expected %b actual %b", case_name[c], outstanding, vld);
                err_cnt++;
            end
            for (int p = 0; p < tcdm_pkg::NumIn; p++) begin
                if (outstanding[p] && !case_wen[c][p]) begin
                    assert (rdata[p] === exp_rdata[p]) else begin
                        $display("error %s port %0d rdata expected %h actual %h",
                                 case_name[c], p, exp_rdata[p], rdata[p]);
                        err_cnt++;
                    end
                end
            end
            // Model and priority pointers follow the granted requests.
            for (int p = 0; p < tcdm_pkg::NumIn; p++) begin
                if (exp_gnt[p]) begin
                    widx = case_add[c][p][11:2];
                    if (case_wen[c][p]) begin
                        ref_mem[widx] = merge_bytes(ref_mem[widx], case_wdata[c][p],
                                                    case_be[c][p]);
                    end else begin
                        exp_rdata[p] = ref_mem[widx];
                    end
                    rr_ptr[case_add[c][p][3:2]] =
                        tcdm_pkg::port_idx_t'((p + 1) % tcdm_pkg::NumIn);
                end
            end
            // Answers are expected for the predicted grants.
            accepted    = gnt & pending;
            outstanding = exp_gnt;
            pending     = pending & ~accepted;
        end
        report_test(case_name[c], errs_before);
    endtask

    initial begin
        req    = '0;
        add    = '0;
        wen    = '0;
        wdata  = '0;
        be     = '0;
        arst_n = 1'b0;
        for (int b = 0; b < tcdm_pkg::NumOut; b++) begin
            rr_ptr[b] = '0;
        end
        read_cases();
        if (num_cases == 0) begin
            $display("no test cases were loaded from tcdm_cases.txt");
            err_cnt++;
        end
        cycle_limit = CyclesPerCase * num_cases + ResetCycles + 2;
        check_reset_state();
        for (int c = 0; c < num_cases; c++) begin
            run_case(c);
        end
        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tcdm_cases.txt
# name mask, then per port 0..3: wen addr wdata be (all hex)
# wen 1 is a write; ports outside the mask are ignored
rr_first_writes  f  1 0000000c 30303030 f  1 0000001c 31313131 f  1 0000002c 32323232 f  1 0000003c 33333333 f
wr_bank0         1  1 00000100 a0a0a0a0 f  0 00000000 00000000 0  0 00000000 00000000 0  0 00000000 00000000 0
wr_bank1         1  1 00000104 b1b1b1b1 f  0 00000000 00000000 0  0 00000000 00000000 0  0 00000000 00000000 0
wr_bank2         1  1 00000108 c2c2c2c2 f  0 00000000 00000000 0  0 00000000 00000000 0  0 00000000 00000000 0
wr_bank3         1  1 0000010c d3d3d3d3 f  0 00000000 00000000 0  0 00000000 00000000 0  0 00000000 00000000 0
rd_bank0         1  0 00000100 00000000 0  0 00000000 00000000 0  0 00000000 00000000 0  0 00000000 00000000 0
rd_bank1         1  0 00000104 00000000 0  0 00000000 00000000 0  0 00000000 00000000 0  0 00000000 00000000 0
rd_bank2         1  0 00000108 00000000 0  0 00000000 00000000 0  0 00000000 00000000 0  0 00000000 00000000 0
rd_bank3         1  0 0000010c 00000000 0  0 00000000 00000000 0  0 00000000 00000000 0  0 00000000 00000000 0
be_low_half      2  0 00000000 00000000 0  1 00000104 12345566 3  0 00000000 00000000 0  0 00000000 00000000 0
be_high_half     2  0 00000000 00000000 0  1 00000108 77889abc c  0 00000000 00000000 0  0 00000000 00000000 0
be_read_bank1    2  0 00000000 00000000 0  0 00000104 00000000 0  0 00000000 00000000 0  0 00000000 00000000 0
be_read_bank2    2  0 00000000 00000000 0  0 00000108 00000000 0  0 00000000 00000000 0  0 00000000 00000000 0
par_write        f  1 00000200 10000001 f  1 00000204 20000002 f  1 00000208 30000003 f  1 0000020c 40000004 f
par_read         f  0 00000204 00000000 0  0 00000208 00000000 0  0 0000020c 00000000 0  0 00000200 00000000 0
rr_same_word     f  0 0000010c 00000000 0  0 0000010c 00000000 0  0 0000010c 00000000 0  0 0000010c 00000000 0
rr_mixed_rw      f  0 0000001c 00000000 0  1 0000000c 5a5a0f0f f  0 0000000c 00000000 0  1 0000003c 0badf00d 6
rr_read_back     f  0 0000000c 00000000 0  0 0000001c 00000000 0  0 0000002c 00000000 0  0 0000003c 00000000 0
alias_write      4  0 00000000 00000000 0  0 00000000 00000000 0  1 00000340 5a5aa5a5 f  0 00000000 00000000 0
alias_high_bits  4  0 00000000 00000000 0  0 00000000 00000000 0  0 fff00340 00000000 0  0 00000000 00000000 0
alias_byte_off   8  0 00000000 00000000 0  0 00000000 00000000 0  0 00000000 00000000 0  0 00000343 00000000 0
alias_both       1  0 12345341 00000000 0  0 00000000 00000000 0  0 00000000 00000000 0  0 00000000 00000000 0
alias_be_write   2  0 00000000 00000000 0  1 80000341 000000ee 1  0 00000000 00000000 0  0 00000000 00000000 0
alias_be_read    8  0 00000000 00000000 0  0 00000000 00000000 0  0 00000000 00000000 0  0 00000340 00000000 0

// File: compile.f
tcdm_pkg.sv
tcdm_mem_if.sv
tcdm_rr_arbiter.sv
tcdm_bank.sv
tcdm_xbar.sv
tcdm_interconnect_wrap.sv
tb_tcdm.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for the fail message.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

# A failed build or run also counts as a failing simulation.
verilator --binary --assert --top-module tb_tcdm -f compile.f > sim.log 2>&1 \
    && ./obj_dir/Vtb_tcdm >> sim.log 2>&1 \
    || echo "STATUS: FAIL" >> sim.log

cat sim.log
if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
exit 0
